//--- all.f
verilog/conf_pkg.sv
verilog/conf_wb_slave.sv
verilog/mem_port_conf.sv
verilog/alu_conf_bank.sv
verilog/muladd_conf_bank.sv
verilog/conf_reg_top.sv
verif/tb_clock_gen.sv
verif/conf_reg_tb.sv

//--- verif/conf_patterns.txt
// records are opcode_address_data, opcode 1 write, 2 read, 3 check
// a check's data is the expected field value, address 00 checks every unit
3_00_00000000
1_10_abcd1234 3_20_00000000 3_10_00000234 1_20_000007ff 3_20_000003ff 3_10_00000234
1_11_00000035 3_21_00000000 3_11_00000015 1_21_ffffffe7 3_21_00000007 3_11_00000015
1_12_0000002a 3_22_00000000 3_12_0000000a 1_22_12345671 3_22_00000011 3_12_0000000a
1_13_0000001f 3_23_00000000 3_13_0000001f 1_23_000000c3 3_23_00000003 3_13_0000001f
1_14_00000c01 3_24_00000000 3_14_00000001 1_24_5555aaaa 3_24_000002aa 3_14_00000001
1_15_00000123 3_25_00000000 3_15_00000123 1_25_ffffffff 3_25_000003ff 3_15_00000123
1_16_00000401 3_26_00000000 3_16_00000001 1_26_0000beef 3_26_000002ef 3_16_00000001
1_17_00000038 3_27_00000000 3_17_00000018 1_27_00000025 3_27_00000005 3_17_00000018
1_18_00000003 3_28_00000000 3_18_00000001 1_28_000000f1 3_28_00000001 3_18_00000001
1_19_80000001 3_29_00000000 3_19_00000001 1_29_00000007 3_29_00000001 3_19_00000001
1_40_0000002b 3_48_00000000 3_40_0000000b 1_48_00000011 3_48_00000011 3_40_0000000b
1_41_00000046 3_49_00000000 3_41_00000006 1_49_0000007e 3_49_0000001e 3_41_00000006
1_42_0000001d 3_4a_00000000 3_42_0000000d 1_4a_000000f3 3_4a_00000003 3_42_0000000d
1_60_000000e9 3_60_00000009 1_61_00000036 3_61_00000016 1_62_0000000e 3_62_00000002
1_63_00012345 3_63_00000345 1_64_00000021 3_64_00000001 1_65_0000003c 3_65_0000001c
1_66_000000ff 3_66_0000001f 3_40_0000000b 3_29_00000001
2_00_00000000 3_66_0000001f 3_19_00000001 3_4a_00000003
1_00_deadbeef 3_00_00000000
2_12_0000001f 1_05_ffffffff 1_35_ffffffff 1_5a_ffffffff 1_71_ffffffff 1_1c_ffffffff
1_45_ffffffff 1_68_ffffffff 1_67_ffffffff 3_00_00000000

//--- verif/conf_reg_tb.sv
`timescale 1ns/1ps

module conf_reg_tb;
   import conf_pkg::*;

   localparam int MAX_RECS = 256;

   logic                  rst;
   logic                  clk;
   logic                  cyc;
   logic                  stb;
   logic                  we;
   conf_addr_u            adr;
   logic [DATA_W-1:0]     dat_w;
   logic                  ack;
   mem_conf_t             mem_conf [N_MEM];
   alu_conf_t             alu_conf [N_ALU];
   muladd_conf_t          muladd_conf [N_MULADD];

   // opcode, address, data
   logic [43:0]           recs [MAX_RECS];
   int                    n_rec;
   int                    cycle_count = 0;
   int                    cycle_limit = 0;

   tb_clock_gen clock_i (
      .rst (rst),
      .clk (clk)
   );

   conf_reg_top dut_i (
      .rst         (rst),
      .clk         (clk),
      .cyc         (cyc),
      .stb         (stb),
      .we          (we),
      .adr         (adr),
      .dat_w       (dat_w),
      .ack         (ack),
      .mem_conf    (mem_conf),
      .alu_conf    (alu_conf),
      .muladd_conf (muladd_conf)
   );

   task automatic stop_with_failure;
      $display("Simulation failed");
      $fatal(1);
   endtask

   task automatic compare_values(input string name, input logic [63:0] expected,
                                 input logic [63:0] actual);
      if (actual !== expected) begin
         $display("[ERROR] %s: expected %0h, actual %0h", name, expected, actual);
         stop_with_failure();
      end
   endtask

   // one Wishbone classic transfer, returns in the cycle where ack is high
   task automatic bus_transfer(input logic write, input logic [CONF_ADDR_W-1:0] addr,
                               input logic [DATA_W-1:0] data, input string name);
      int waited;
      @(posedge rst);
      #1;
      compare_values({name, " ack low before cycle"}, 64'd0, 64'(ack));
      cyc   = 1'b1;
      stb   = 1'b1;
      we    = write;
      adr   = addr;
      dat_w = data;
      waited = 0;
      do begin
         @(posedge rst);
         #1;
         waited++;
      end while (ack !== 1'b1);
      compare_values({name, " ack latency"}, 64'd1, 64'(waited));
      cyc = 1'b0;
      stb = 1'b0;
      we  = 1'b0;
   endtask

   function automatic logic [63:0] field_value(input conf_addr_u a, output logic found);
      int p;
      found = 1'b1;
      field_value = '0;
      case (a.mem_view.region)
         REGION_MEM0, REGION_MEM0 + 3'd1: begin
            p = int'(a.mem_view.region - REGION_MEM0);
            case (a.mem_view.field)
               MEM_F_ITER:  field_value = mem_conf[p].iter;
               MEM_F_PER:   field_value = mem_conf[p].per;
               MEM_F_DUTY:  field_value = mem_conf[p].duty;
               MEM_F_SEL:   field_value = mem_conf[p].sel;
               MEM_F_START: field_value = mem_conf[p].start;
               MEM_F_SHIFT: field_value = mem_conf[p].shift;
               MEM_F_INCR:  field_value = mem_conf[p].incr;
               MEM_F_DELAY: field_value = mem_conf[p].delay;
               MEM_F_EXT:   field_value = mem_conf[p].ext;
               MEM_F_IN_WR: field_value = mem_conf[p].in_wr;
               default:     found = 1'b0;
            endcase
         end
         REGION_ALU: begin
            case (a.fu_view.field)
               ALU_F_SELA: field_value = alu_conf[a.fu_view.unit].sela;
               ALU_F_SELB: field_value = alu_conf[a.fu_view.unit].selb;
               ALU_F_FNS:  field_value = alu_conf[a.fu_view.unit].fns;
               default:    found = 1'b0;
            endcase
         end
         REGION_MULADD: begin
            if (a.fu_view.unit != 1'b0) begin
               found = 1'b0;
            end else begin
               case (a.fu_view.field)
                  MULADD_F_SELA:  field_value = muladd_conf[0].sela;
                  MULADD_F_SELB:  field_value = muladd_conf[0].selb;
                  MULADD_F_FNS:   field_value = muladd_conf[0].fns;
                  MULADD_F_ITER:  field_value = muladd_conf[0].iter;
                  MULADD_F_PER:   field_value = muladd_conf[0].per;
                  MULADD_F_DELAY: field_value = muladd_conf[0].delay;
                  MULADD_F_SHIFT: field_value = muladd_conf[0].shift;
                  default:        found = 1'b0;
               endcase
            end
         end
         default: found = 1'b0;
      endcase
   endfunction

   // address 0 compares every whole unit against the data word
   task automatic check_record(input logic [CONF_ADDR_W-1:0] addr,
                               input logic [DATA_W-1:0] expected, input string name);
      logic        found;
      logic [63:0] actual;
      if (addr == CONF_CLEAR_ADDR) begin
         for (int i = 0; i < N_MEM; i++) begin
            compare_values($sformatf("%s mem %0d", name, i), 64'(expected), 64'(mem_conf[i]));
         end
         for (int i = 0; i < N_ALU; i++) begin
            compare_values($sformatf("%s alu %0d", name, i), 64'(expected), 64'(alu_conf[i]));
         end
         for (int i = 0; i < N_MULADD; i++) begin
            compare_values($sformatf("%s muladd %0d", name, i), 64'(expected),
                           64'(muladd_conf[i]));
         end
      end else begin
         actual = field_value(addr, found);
         if (!found) begin
            $display("%s names no configuration field at address %0h", name, addr);
            stop_with_failure();
         end
         compare_values(name, 64'(expected), actual);
      end
   endtask

   always @(posedge rst) begin
      cycle_count++;
      if (cycle_count >= cycle_limit) begin
         $display("timeout: no acknowledge from the configuration port");
         stop_with_failure();
      end
   end

   initial begin
      logic [3:0]  op;
      logic [7:0]  addr;
      logic [31:0] data;
      string       name;
      cyc   = 1'b0;
      stb   = 1'b0;
      we    = 1'b0;
      adr   = '0;
      dat_w = '0;
      for (int i = 0; i < MAX_RECS; i++) begin
         recs[i] = '0;
      end
      $readmemh("verif/conf_patterns.txt", recs);
      n_rec = 0;
      while (n_rec < MAX_RECS && recs[n_rec][43:40] != 4'd0) begin
         n_rec++;
      end
      cycle_limit = 3 * n_rec + 20;
      if (n_rec == 0) begin
         $display("pattern file is missing or holds no records");
         stop_with_failure();
      end
      @(negedge clk);
      @(posedge rst);
      #1;
      compare_values("ack after reset", 64'd0, 64'(ack));
      for (int i = 0; i < n_rec; i++) begin
         op   = recs[i][43:40];
         addr = recs[i][39:32];
         data = recs[i][31:0];
         name = $sformatf("record %0d at %02h", i, addr);
         case (op)
            4'd1:    bus_transfer(1'b1, addr[CONF_ADDR_W-1:0], data, {name, " write"});
            4'd2:    bus_transfer(1'b0, addr[CONF_ADDR_W-1:0], data, {name, " read"});
            4'd3:    check_record(addr[CONF_ADDR_W-1:0], data, {name, " check"});
            default: begin
               $display("%s has an unknown opcode %0h", name, op);
               stop_with_failure();
            end
         endcase
      end
      // last ack must also drop after one cycle
      @(posedge rst);
      #1;
      compare_values("ack low after last cycle", 64'd0, 64'(ack));
      $display("Simulation completed successfully");
      $finish;
   end

endmodule

//--- verif/tb_clock_gen.sv
`timescale 1ns/1ps

module tb_clock_gen (
   output logic rst,
   output logic clk
);

   // rst is the clock, clk the active high reset
   initial begin
      rst = 1'b0;
      forever #50 rst = ~rst;
   end

   initial begin
      clk = 1'b1;
      repeat (2) @(posedge rst);
      #1 clk = 1'b0;
   end

endmodule

//--- verilog/alu_conf_bank.sv
`timescale 1ns/1ps

module alu_conf_bank (
   input  logic                rst,
   input  logic                clk,
   input  conf_pkg::conf_wr_t  wr,
   input  logic                clear,
   output conf_pkg::alu_conf_t alu_conf [conf_pkg::N_ALU]
);
   import conf_pkg::*;

   logic region_hit;

   assign region_hit = wr.en && (wr.addr.fu_view.region == REGION_ALU);

   always_ff @(posedge rst, posedge clk) begin
      if (clk) begin
         for (int i = 0; i < N_ALU; i++) begin
            alu_conf[i] <= '0;
         end
      end else if (clear) begin
         for (int i = 0; i < N_ALU; i++) begin
            alu_conf[i] <= '0;
         end
      end else if (region_hit) begin
         for (int i = 0; i < N_ALU; i++) begin
            if (wr.addr.fu_view.unit == 1'(i)) begin
               case (wr.addr.fu_view.field)
                  ALU_F_SELA: alu_conf[i].sela <= wr.data[N_W-1:0];
                  ALU_F_SELB: alu_conf[i].selb <= wr.data[N_W-1:0];
                  ALU_F_FNS:  alu_conf[i].fns  <= wr.data[ALU_FNS_W-1:0];
                  // 3 to 7 unused
                  default: begin
                  end
               endcase
            end
         end
      end
   end

endmodule

//--- verilog/conf_pkg.sv
package conf_pkg;

   localparam int DATA_W       = 32;
   localparam int CONF_ADDR_W  = 7;
   localparam int MEM_ADDR_W   = 10;
   localparam int PERIOD_W     = 5;
   localparam int N_W          = 5;
   localparam int ALU_FNS_W    = 4;
   localparam int MULADD_FNS_W = 2;
   localparam int SHIFT_W      = 5;

   localparam int N_MEM    = 2;
   localparam int N_ALU    = 2;
   localparam int N_MULADD = 1;

   // top three address bits select the region
   localparam logic [2:0] REGION_CLEAR  = 3'd0;
   localparam logic [2:0] REGION_MEM0   = 3'd1;
   localparam logic [2:0] REGION_ALU    = 3'd4;
   localparam logic [2:0] REGION_MULADD = 3'd6;

   localparam logic [CONF_ADDR_W-1:0] CONF_CLEAR_ADDR = {REGION_CLEAR, 4'd0};

   // memory port field codes
   localparam logic [3:0] MEM_F_ITER  = 4'd0;
   localparam logic [3:0] MEM_F_PER   = 4'd1;
   localparam logic [3:0] MEM_F_DUTY  = 4'd2;
   localparam logic [3:0] MEM_F_SEL   = 4'd3;
   localparam logic [3:0] MEM_F_START = 4'd4;
   localparam logic [3:0] MEM_F_SHIFT = 4'd5;
   localparam logic [3:0] MEM_F_INCR  = 4'd6;
   localparam logic [3:0] MEM_F_DELAY = 4'd7;
   localparam logic [3:0] MEM_F_EXT   = 4'd8;
   localparam logic [3:0] MEM_F_IN_WR = 4'd9;

   localparam logic [2:0] ALU_F_SELA = 3'd0;
   localparam logic [2:0] ALU_F_SELB = 3'd1;
   localparam logic [2:0] ALU_F_FNS  = 3'd2;

   localparam logic [2:0] MULADD_F_SELA  = 3'd0;
   localparam logic [2:0] MULADD_F_SELB  = 3'd1;
   localparam logic [2:0] MULADD_F_FNS   = 3'd2;
   localparam logic [2:0] MULADD_F_ITER  = 3'd3;
   localparam logic [2:0] MULADD_F_PER   = 3'd4;
   localparam logic [2:0] MULADD_F_DELAY = 3'd5;
   localparam logic [2:0] MULADD_F_SHIFT = 3'd6;

   typedef struct packed {
      logic [2:0] region;
      logic [3:0] field;
   } mem_addr_t;

   // alu and muladd units, 8 addresses per unit
   typedef struct packed {
      logic [2:0] region;
      logic       unit;
      logic [2:0] field;
   } fu_addr_t;

   typedef union packed {
      mem_addr_t mem_view;
      fu_addr_t  fu_view;
   } conf_addr_u;

   typedef struct packed {
      logic              en;
      conf_addr_u        addr;
      logic [DATA_W-1:0] data;
   } conf_wr_t;

   typedef struct packed {
      logic [MEM_ADDR_W-1:0] iter;
      logic [PERIOD_W-1:0]   per;
      logic [PERIOD_W-1:0]   duty;
      logic [N_W-1:0]        sel;
      logic [MEM_ADDR_W-1:0] start;
      logic [MEM_ADDR_W-1:0] shift;
      logic [MEM_ADDR_W-1:0] incr;
      logic [PERIOD_W-1:0]   delay;
      logic                  ext;
      logic                  in_wr;
   } mem_conf_t;

   typedef struct packed {
      logic [N_W-1:0]       sela;
      logic [N_W-1:0]       selb;
      logic [ALU_FNS_W-1:0] fns;
   } alu_conf_t;

   typedef struct packed {
      logic [N_W-1:0]          sela;
      logic [N_W-1:0]          selb;
      logic [MULADD_FNS_W-1:0] fns;
      logic [MEM_ADDR_W-1:0]   iter;
      logic [PERIOD_W-1:0]     per;
      logic [PERIOD_W-1:0]     delay;
      logic [SHIFT_W-1:0]      shift;
   } muladd_conf_t;

endpackage

//--- verilog/conf_reg_top.sv
`timescale 1ns/1ps

module conf_reg_top (
   input  logic                        rst,
   input  logic                        clk,
   input  logic                        cyc,
   input  logic                        stb,
   input  logic                        we,
   input  conf_pkg::conf_addr_u        adr,
   input  logic [conf_pkg::DATA_W-1:0] dat_w,
   output logic                        ack,
   output conf_pkg::mem_conf_t         mem_conf [conf_pkg::N_MEM],
   output conf_pkg::alu_conf_t         alu_conf [conf_pkg::N_ALU],
   output conf_pkg::muladd_conf_t      muladd_conf [conf_pkg::N_MULADD]
);
   import conf_pkg::*;

   conf_wr_t wr;
   logic     clear;

   conf_wb_slave slave_i (
      .rst   (rst),
      .clk   (clk),
      .cyc   (cyc),
      .stb   (stb),
      .we    (we),
      .adr   (adr),
      .dat_w (dat_w),
      .ack   (ack),
      .wr    (wr),
      .clear (clear)
   );

   // every bank sees the same pulse and decodes its own region
   mem_port_conf mem_i (
      .rst      (rst),
      .clk      (clk),
      .wr       (wr),
      .clear    (clear),
      .mem_conf (mem_conf)
   );

   alu_conf_bank alu_i (
      .rst      (rst),
      .clk      (clk),
      .wr       (wr),
      .clear    (clear),
      .alu_conf (alu_conf)
   );

   muladd_conf_bank muladd_i (
      .rst         (rst),
      .clk         (clk),
      .wr          (wr),
      .clear       (clear),
      .muladd_conf (muladd_conf)
   );

endmodule

//--- verilog/conf_wb_slave.sv
`timescale 1ns/1ps

module conf_wb_slave (
   input  logic                                rst,
   input  logic                                clk,
   input  logic                                cyc,
   input  logic                                stb,
   input  logic                                we,
   input  conf_pkg::conf_addr_u                adr,
   input  logic [conf_pkg::DATA_W-1:0]         dat_w,
   output logic                                ack,
   output conf_pkg::conf_wr_t                  wr,
   output logic                                clear
);
   import conf_pkg::*;

   logic accept;
   logic clear_hit;

   // new cycle only while ack is low, so each transfer is taken once
   assign accept    = cyc & stb & ~ack;
   assign clear_hit = (adr == CONF_CLEAR_ADDR);

   always_ff @(posedge rst, posedge clk) begin
      if (clk) begin
         ack <= 1'b0;
      end else begin
         ack <= accept;
      end
   end

   // reads are acked but never reach the banks
   assign wr.en   = accept & we & ~clear_hit;
   assign wr.addr = adr;
   assign wr.data = dat_w;
   assign clear   = accept & we & clear_hit;

   ack_one_cycle: assert property (
      @(posedge rst) disable iff (clk)
      ack |=> !ack
   );

   // a bank never sees a field write and a clear on the same edge
   wr_clear_excl: assert property (
      @(posedge rst) disable iff (clk)
      !(wr.en && clear)
   );

endmodule

//--- verilog/mem_port_conf.sv
`timescale 1ns/1ps

module mem_port_conf (
   input  logic                rst,
   input  logic                clk,
   input  conf_pkg::conf_wr_t  wr,
   input  logic                clear,
   output conf_pkg::mem_conf_t mem_conf [conf_pkg::N_MEM]
);
   import conf_pkg::*;

   logic [N_MEM-1:0] port_hit;

   // port i lives in region REGION_MEM0+i
   always_comb begin
      for (int i = 0; i < N_MEM; i++) begin
         port_hit[i] = wr.en && (wr.addr.mem_view.region == REGION_MEM0 + 3'(i));
      end
   end

   always_ff @(posedge rst, posedge clk) begin
      if (clk) begin
         for (int i = 0; i < N_MEM; i++) begin
            mem_conf[i] <= '0;
         end
      end else if (clear) begin
         for (int i = 0; i < N_MEM; i++) begin
            mem_conf[i] <= '0;
         end
      end else begin
         for (int i = 0; i < N_MEM; i++) begin
            if (port_hit[i]) begin
               // codes 10 to 15 fall through
               case (wr.addr.mem_view.field)
                  MEM_F_ITER:  mem_conf[i].iter  <= wr.data[MEM_ADDR_W-1:0];
                  MEM_F_PER:   mem_conf[i].per   <= wr.data[PERIOD_W-1:0];
                  MEM_F_DUTY:  mem_conf[i].duty  <= wr.data[PERIOD_W-1:0];
                  MEM_F_SEL:   mem_conf[i].sel   <= wr.data[N_W-1:0];
                  MEM_F_START: mem_conf[i].start <= wr.data[MEM_ADDR_W-1:0];
                  MEM_F_SHIFT: mem_conf[i].shift <= wr.data[MEM_ADDR_W-1:0];
                  MEM_F_INCR:  mem_conf[i].incr  <= wr.data[MEM_ADDR_W-1:0];
                  MEM_F_DELAY: mem_conf[i].delay <= wr.data[PERIOD_W-1:0];
                  MEM_F_EXT:   mem_conf[i].ext   <= wr.data[0];
                  MEM_F_IN_WR: mem_conf[i].in_wr <= wr.data[0];
                  default: begin
                  end
               endcase
            end
         end
      end
   end

   // outside a clear, no two ports move on the same edge
   for (genvar a = 0; a < N_MEM; a++) begin : g_port_a
      for (genvar b = a + 1; b < N_MEM; b++) begin : g_port_b
         one_port_per_write: assert property (
            @(posedge rst) disable iff (clk)
            !clear |=> !($changed(mem_conf[a]) && $changed(mem_conf[b]))
         );
      end
   end

endmodule

//--- verilog/muladd_conf_bank.sv
`timescale 1ns/1ps

module muladd_conf_bank (
   input  logic                   rst,
   input  logic                   clk,
   input  conf_pkg::conf_wr_t     wr,
   input  logic                   clear,
   output conf_pkg::muladd_conf_t muladd_conf [conf_pkg::N_MULADD]
);
   import conf_pkg::*;

   logic region_hit;

   assign region_hit = wr.en && (wr.addr.fu_view.region == REGION_MULADD);

   always_ff @(posedge rst, posedge clk) begin
      if (clk) begin
         for (int i = 0; i < N_MULADD; i++) begin
            muladd_conf[i] <= '0;
         end
      end else if (clear) begin
         for (int i = 0; i < N_MULADD; i++) begin
            muladd_conf[i] <= '0;
         end
      end else if (region_hit) begin
         // unit index past N_MULADD matches no entry
         for (int i = 0; i < N_MULADD; i++) begin
            if (wr.addr.fu_view.unit == 1'(i)) begin
               case (wr.addr.fu_view.field)
                  MULADD_F_SELA:  muladd_conf[i].sela  <= wr.data[N_W-1:0];
                  MULADD_F_SELB:  muladd_conf[i].selb  <= wr.data[N_W-1:0];
                  MULADD_F_FNS:   muladd_conf[i].fns   <= wr.data[MULADD_FNS_W-1:0];
                  MULADD_F_ITER:  muladd_conf[i].iter  <= wr.data[MEM_ADDR_W-1:0];
                  MULADD_F_PER:   muladd_conf[i].per   <= wr.data[PERIOD_W-1:0];
                  MULADD_F_DELAY: muladd_conf[i].delay <= wr.data[PERIOD_W-1:0];
                  MULADD_F_SHIFT: muladd_conf[i].shift <= wr.data[SHIFT_W-1:0];
                  default: begin
                  end
               endcase
            end
         end
      end
   end

   // a field only moves on a write into this region for a present unit
   for (genvar g = 0; g < N_MULADD; g++) begin : g_unit_chk
      unit_in_range: assert property (
         @(posedge rst) disable iff (clk)
         ($changed(muladd_conf[g]) && !$past(clear)) |->
            ($past(wr.addr.fu_view.region) == REGION_MULADD &&
             $past(wr.addr.fu_view.unit) < N_MULADD)
      );
   end

endmodule
